/* src.f */
+incdir+include
verilog/xcom_pkg.sv
verilog/xcom_link_rx.sv
verilog/rx_cmd.sv
verilog/xcom_cmd_exec.sv
verilog/xcom_rx_top.sv
sim/tb_xcom_rx.sv

/* Makefile */
# Verilator build and run for the command link receive side.
# Any variable can be overridden on the command line, e.g. make sim TOP=tb_xcom_rx

VERILATOR ?= verilator
TOP       ?= tb_xcom_rx
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# Build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_xcom_rx.sv */
`timescale 1ns/1ps
// Testbench for the receive top that drives serial frames on two channels
// and checks the executor state against a reference model after every command.
`include "xcom_defines.svh"

module tb_xcom_rx;
   import xcom_pkg::*;

   localparam int NCH            = 2;
   localparam int TIMEOUT_CYCLES = 40 * 200;

   logic                       clk;
   logic                       rstn;
   logic [3:0]                 id;
   logic [NCH-1:0]             xdata;
   logic [NCH-1:0]             xclk;
   logic [31:0]                o_reg;
   logic [7:0]                 o_flags;
   logic                       o_sync;
   logic [15:0]                o_cmd_cnt;
   logic [7:0]                 o_err_cnt;
   logic [3:0]                 o_last_chid;
   logic [NCH-1:0][4:0]        o_dbg_state;

   // Reference model
   logic [31:0] m_reg;
   logic [7:0]  m_flags;
   logic        m_sync;
   logic [15:0] m_cmd_cnt;
   logic [7:0]  m_err_cnt;
   logic [3:0]  m_last_chid;

   int   cycle_cnt   = 0;
   int   sync_pulses = 0;
   logic sync_prev   = 1'b0;

   xcom_rx_top #(.NCH(NCH)) i_dut (
      .i_clk       (clk),
      .i_rstn      (rstn),
      .i_id        (id),
      .i_xcom_data (xdata),
      .i_xcom_clk  (xclk),
      .o_reg       (o_reg),
      .o_flags     (o_flags),
      .o_sync      (o_sync),
      .o_cmd_cnt   (o_cmd_cnt),
      .o_err_cnt   (o_err_cnt),
      .o_last_chid (o_last_chid),
      .o_dbg_state (o_dbg_state)
   );

   ////////////////////
   // Clock and watchdog
   ////////////////////
   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Run timed out after %0d cycles waiting for the DUT", cycle_cnt);
         $display("TESTBENCH FAILED");
         $fatal(1, "Timeout");
      end
   end

   // Sync pulse must stay one cycle wide
   always @(negedge clk) begin
      if (rstn) begin
         assert (!(o_sync && sync_prev)) else begin
            $display("o_sync stayed high for more than one cycle");
            $display("TESTBENCH FAILED");
            $fatal(1, "Sync width");
         end
         if (o_sync && !sync_prev) sync_pulses = sync_pulses + 1;
         sync_prev = o_sync;
      end
   end

   ////////////////////
   // Checking
   ////////////////////
   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s is %h, expected %h", name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic match_model();
      compare_value("o_reg", o_reg, m_reg);
      compare_value("o_flags", 32'(o_flags), 32'(m_flags));
      compare_value("o_sync", 32'(o_sync), 32'(m_sync));
      compare_value("o_cmd_cnt", 32'(o_cmd_cnt), 32'(m_cmd_cnt));
      compare_value("o_err_cnt", 32'(o_err_cnt), 32'(m_err_cnt));
      compare_value("o_last_chid", 32'(o_last_chid), 32'(m_last_chid));
   endtask

   // Nothing executed and both link FSMs back in idle
   task automatic expect_idle();
      m_sync = 1'b0;
      match_model();
      compare_value("o_dbg_state[0]", 32'(o_dbg_state[0]), 32'(LNK_IDLE));
      compare_value("o_dbg_state[1]", 32'(o_dbg_state[1]), 32'(LNK_IDLE));
   endtask

   // Opcode rules of the executor
   task automatic model_apply(input logic [3:0] op, input logic [31:0] data,
                              input logic [3:0] ch);
      m_sync = 1'b0;
      if (op > 4'd5) begin
         m_err_cnt = m_err_cnt + 8'd1;
      end else begin
         m_cmd_cnt   = m_cmd_cnt + 16'd1;
         m_last_chid = ch;
         case (op)
            4'd1: m_reg = data;
            4'd2: m_reg = m_reg + data;
            4'd3: m_flags = m_flags | data[7:0];
            4'd4: m_flags = m_flags & ~data[7:0];
            4'd5: m_sync = 1'b1;
            default: m_sync = 1'b0;
         endcase
      end
   endtask

   ////////////////////
   // Frame driver
   ////////////////////
   // Data set first and strobe toggled two cycles later within each 4-cycle bit
   task automatic send_bits(input int ch, input logic [39:0] frame, input int nbits);
      @(posedge clk);
      #1;
      for (int i = 39; i > 39 - nbits; i--) begin
         xdata[ch] = frame[i];
         repeat (2) @(posedge clk);
         #1 xclk[ch] = ~xclk[ch];
         repeat (2) @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_change(input logic [15:0] cmd0, input logic [7:0] err0);
      @(negedge clk);
      while (o_cmd_cnt == cmd0 && o_err_cnt == err0) @(negedge clk);
   endtask

   task automatic run_frame(input int ch, input logic [3:0] op, input logic [3:0] dest,
                            input logic [31:0] data);
      logic [15:0] cmd0;
      logic [7:0]  err0;
      cmd0 = o_cmd_cnt;
      err0 = o_err_cnt;
      send_bits(ch, {op, dest, data}, 40);
      wait_change(cmd0, err0);
      model_apply(op, data, 4'(ch));
      match_model();
   endtask

   ////////////////////
   // Stimulus
   ////////////////////
   initial begin
      logic [31:0] da;
      logic [31:0] db;
      void'($urandom(32'h6d1d));
      rstn  = 1'b0;
      id    = 4'd5;
      xdata = '0;
      xclk  = '0;
      {m_reg, m_flags, m_sync, m_cmd_cnt, m_err_cnt, m_last_chid} = '0;
      repeat (10) @(posedge clk);
      #1 rstn = 1'b1;
      @(negedge clk);
      expect_idle();

      // Load then add on channel 0
      run_frame(0, OP_LOAD, 4'd5, $urandom);
      run_frame(0, OP_ADD, 4'd5, $urandom);

      // Other board's ID is dropped and broadcast is kept
      send_bits(0, {OP_LOAD, 4'd9, 32'(($urandom))}, 40);
      repeat (20) @(negedge clk);
      expect_idle();
      run_frame(1, OP_ADD, 4'd0, $urandom);

      // Both channels at once with channel 0 winning
      da = $urandom;
      db = $urandom;
      fork
         send_bits(0, {OP_LOAD, 4'd5, da}, 40);
         send_bits(1, {OP_LOAD, 4'd5, db}, 40);
      join
      wait_change(m_cmd_cnt, m_err_cnt);
      model_apply(OP_LOAD, da, 4'd0);
      match_model();
      wait_change(m_cmd_cnt, m_err_cnt);
      model_apply(OP_LOAD, db, 4'd1);
      match_model();

      // Flags and sync
      run_frame(0, OP_FLAG_SET, 4'd5, $urandom);
      run_frame(1, OP_FLAG_CLR, 4'd5, $urandom);
      run_frame(0, OP_SYNC, 4'd5, $urandom);

      // Illegal opcode only bumps the error count
      run_frame(1, 4'd12, 4'd5, $urandom);

      // Partial frame times out and the next one still lands
      send_bits(0, {OP_LOAD, 4'd5, 32'(($urandom))}, 20);
      repeat (`XCOM_LINK_TIMEOUT + 20) @(negedge clk);
      expect_idle();
      run_frame(0, OP_LOAD, 4'd5, $urandom);

      repeat (10) @(negedge clk);
      if (sync_pulses != 1) begin
         $display("Expected one o_sync pulse during the run, saw %0d", sync_pulses);
         $display("TESTBENCH FAILED");
         $fatal(1, "Sync count");
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

/* verilog/xcom_rx_top.sv */
`timescale 1ns/1ps
// Top of the receive side: serial channels in, executed command state out.
`include "xcom_defines.svh"

module xcom_rx_top #(
   parameter int NCH = `XCOM_NCH
)(
   input  logic                       i_clk      ,
   input  logic                       i_rstn     ,
   input  logic [`XCOM_ID_BITS-1:0]   i_id       ,
   // Serial wires
   input  logic [NCH-1:0]             i_xcom_data,
   input  logic [NCH-1:0]             i_xcom_clk ,
   // Executor state
   output logic [`XCOM_DATA_BITS-1:0] o_reg      ,
   output logic [7:0]                 o_flags    ,
   output logic                       o_sync     ,
   output logic [15:0]                o_cmd_cnt  ,
   output logic [7:0]                 o_err_cnt  ,
   output logic [`XCOM_CHID_BITS-1:0] o_last_chid,
   // Link FSM states
   output logic [NCH-1:0][4:0]        o_dbg_state
);
   import xcom_pkg::*;

   // Arbiter to executor
   logic      s_valid;
   xcom_cmd_t s_cmd;

   rx_cmd #(
      .NCH ( NCH )
   ) u_rx_cmd (
      .i_clk       ( i_clk       ),
      .i_rstn      ( i_rstn      ),
      .i_id        ( i_id        ),
      .i_xcom_data ( i_xcom_data ),
      .i_xcom_clk  ( i_xcom_clk  ),
      .o_valid     ( s_valid     ),
      .o_cmd       ( s_cmd       ),
      .o_dbg_state ( o_dbg_state )
   );

   xcom_cmd_exec u_cmd_exec (
      .i_clk       ( i_clk       ),
      .i_rstn      ( i_rstn      ),
      .i_valid     ( s_valid     ),
      .i_cmd       ( s_cmd       ),
      .o_reg       ( o_reg       ),
      .o_flags     ( o_flags     ),
      .o_sync      ( o_sync      ),
      .o_cmd_cnt   ( o_cmd_cnt   ),
      .o_err_cnt   ( o_err_cnt   ),
      .o_last_chid ( o_last_chid )
   );

endmodule

/* verilog/xcom_cmd_exec.sv */
`timescale 1ns/1ps
// Command executor: applies each valid command to a register, flags and a sync pulse.
// Counts legal and illegal commands; accepts a command on every cycle o_valid is high.
`include "xcom_defines.svh"

module xcom_cmd_exec (
   input  logic                       i_clk      ,
   input  logic                       i_rstn     ,
   // Command in, no back-pressure
   input  logic                       i_valid    ,
   input  xcom_pkg::xcom_cmd_t        i_cmd      ,
   // Results
   output logic [`XCOM_DATA_BITS-1:0] o_reg      ,
   output logic [7:0]                 o_flags    ,
   output logic                       o_sync     ,
   output logic [15:0]                o_cmd_cnt  ,
   output logic [7:0]                 o_err_cnt  ,
   output logic [`XCOM_CHID_BITS-1:0] o_last_chid
);
   import xcom_pkg::*;

   logic s_legal;

   ////////////////////
   // Opcode check
   ////////////////////
   always_comb begin
      case (i_cmd.op)
         OP_NOP, OP_LOAD, OP_ADD, OP_FLAG_SET, OP_FLAG_CLR, OP_SYNC: s_legal = 1'b1;
         default:                                                    s_legal = 1'b0;
      endcase
   end

   ////////////////////
   // Execute
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_reg       <= '0;
         o_flags     <= '0;
         o_sync      <= 1'b0;
         o_cmd_cnt   <= '0;
         o_err_cnt   <= '0;
         o_last_chid <= '0;
      end else begin
         // Sync is a single-cycle pulse
         o_sync <= 1'b0;
         if (i_valid && s_legal) begin
            o_cmd_cnt   <= o_cmd_cnt + 1'b1;
            o_last_chid <= i_cmd.chid;
            case (i_cmd.op)
               OP_LOAD:     o_reg   <= i_cmd.data;
               // Wraps modulo 2^32
               OP_ADD:      o_reg   <= o_reg + i_cmd.data;
               OP_FLAG_SET: o_flags <= o_flags | i_cmd.data[7:0];
               OP_FLAG_CLR: o_flags <= o_flags & ~i_cmd.data[7:0];
               OP_SYNC:     o_sync  <= 1'b1;
               // NOP only counts
               default:     o_sync  <= 1'b0;
            endcase
         end else if (i_valid) begin
            // Illegal opcode, nothing else moves
            o_err_cnt <= o_err_cnt + 1'b1;
         end
      end
   end

endmodule

/* verilog/rx_cmd.sv */
`timescale 1ns/1ps
// Receive front end: one link receiver per channel plus a fixed-priority arbiter.
// Emits one command with a single-cycle o_valid per acknowledged frame.
`include "xcom_defines.svh"

module rx_cmd #(
   parameter int NCH = `XCOM_NCH
)(
   input  logic                     i_clk      ,
   input  logic                     i_rstn     ,
   // Local board ID
   input  logic [`XCOM_ID_BITS-1:0] i_id       ,
   // Serial wires, one pair per channel
   input  logic [NCH-1:0]           i_xcom_data,
   input  logic [NCH-1:0]           i_xcom_clk ,
   // Command out
   output logic                     o_valid    ,
   output xcom_pkg::xcom_cmd_t      o_cmd      ,
   // Per-channel FSM state
   output logic [NCH-1:0][4:0]      o_dbg_state
);
   import xcom_pkg::*;

   localparam int CHW = `XCOM_CHID_BITS;

   logic [NCH-1:0] s_req;
   logic [NCH-1:0] s_ack;
   xcom_frame_t    s_frame [NCH];
   xcom_frame_t    s_sel_frame;
   logic           s_any_req;
   logic [CHW-1:0] s_win_ch;
   logic           s_grant;
   logic [CHW-1:0] chid_r;
   logic           ack_r;
   arb_state_t     state_r;
   arb_state_t     state_n;

   ////////////////////
   // Link receivers
   ////////////////////
   for (genvar k = 0; k < NCH; k++) begin : g_rx
      xcom_link_rx u_link_rx (
         .i_clk       ( i_clk          ),
         .i_rstn      ( i_rstn         ),
         .i_id        ( i_id           ),
         .i_xcom_data ( i_xcom_data[k] ),
         .i_xcom_clk  ( i_xcom_clk[k]  ),
         .i_ack       ( s_ack[k]       ),
         .o_req       ( s_req[k]       ),
         .o_frame     ( s_frame[k]     ),
         .o_dbg_state ( o_dbg_state[k] )
      );

      // Ack only reaches the latched channel
      assign s_ack[k] = ack_r && (chid_r == CHW'(k));
   end

   ////////////////////
   // Priority encoder
   ////////////////////
   assign s_any_req = |s_req;

   // Walk down so the lowest index wins
   always_comb begin
      s_win_ch = '0;
      for (int i = NCH - 1; i >= 0; i--) begin
         if (s_req[i]) s_win_ch = CHW'(i);
      end
   end

   ////////////////////
   // Arbiter FSM
   ////////////////////
   // IDLE grants, REQ covers the ack cycle, ACK lets the request drop
   always_comb begin
      state_n = state_r;
      s_grant = 1'b0;
      case (state_r)
         ARB_IDLE: begin
            if (s_any_req) begin
               s_grant = 1'b1;
               state_n = ARB_REQ;
            end
         end
         ARB_REQ: begin
            if (ack_r) state_n = ARB_ACK;
         end
         ARB_ACK: begin
            if (!ack_r) state_n = ARB_IDLE;
         end
         default: state_n = ARB_IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state_r <= ARB_IDLE;
         ack_r   <= 1'b0;
         chid_r  <= '0;
      end else begin
         state_r <= state_n;
         // One-cycle ack pulse per grant
         ack_r   <= s_grant;
         if (s_grant) chid_r <= s_win_ch;
      end
   end

   ////////////////////
   // Command output
   ////////////////////
   // Mux the latched channel's frame
   always_comb begin
      s_sel_frame = s_frame[0];
      for (int i = 1; i < NCH; i++) begin
         if (chid_r == CHW'(i)) s_sel_frame = s_frame[i];
      end
   end

   assign o_cmd.op   = s_sel_frame.op;
   assign o_cmd.data = s_sel_frame.data;
   assign o_cmd.chid = chid_r;
   // Valid is the ack itself, frame still held that cycle
   assign o_valid    = ack_r;

endmodule

/* verilog/xcom_link_rx.sv */
`timescale 1ns/1ps
// Receiver for one serial channel: data plus toggling strobe in, one held frame out.
// Raises o_req for a frame addressed here or broadcast, holds it until i_ack.
`include "xcom_defines.svh"

module xcom_link_rx (
   input  logic                     i_clk      ,
   input  logic                     i_rstn     ,
   // Local board ID
   input  logic [`XCOM_ID_BITS-1:0] i_id       ,
   // Serial wires, asynchronous to i_clk
   input  logic                     i_xcom_data,
   input  logic                     i_xcom_clk ,
   // Request / acknowledge with the arbiter
   input  logic                     i_ack      ,
   output logic                     o_req      ,
   output xcom_pkg::xcom_frame_t    o_frame    ,
   // Debug
   output xcom_pkg::link_state_t    o_dbg_state
);
   import xcom_pkg::*;

   localparam int SYNC_N  = `XCOM_SYNC_STAGES;
   localparam int FRAME_N = `XCOM_FRAME_BITS;
   localparam int CNT_W   = $clog2(FRAME_N + 1);
   localparam int TMO_W   = $clog2(`XCOM_LINK_TIMEOUT + 1);
   // Top bit of the destination field
   localparam int ID_MSB  = FRAME_N - `XCOM_OP_BITS - 1;

   logic [SYNC_N-1:0]        data_sync_r;
   logic [SYNC_N-1:0]        clk_sync_r;
   logic                     clk_prev_r;
   logic                     s_bit;
   logic                     s_toggle;
   logic                     s_shift_en;
   logic                     s_last_bit;
   logic                     s_timeout;
   logic [`XCOM_ID_BITS-1:0] s_dest;
   logic                     s_accept;
   link_state_t              state_r;
   link_state_t              state_n;
   logic [FRAME_N-1:0]       shift_r;
   logic [CNT_W-1:0]         bit_cnt_r;
   logic [TMO_W-1:0]         idle_cnt_r;

   ////////////////////
   // Input synchronizer
   ////////////////////
   // Strobe chain is reset so no false toggle shows up after reset
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         clk_sync_r <= '0;
         clk_prev_r <= 1'b0;
      end else begin
         clk_sync_r <= {clk_sync_r[SYNC_N-2:0], i_xcom_clk};
         clk_prev_r <= clk_sync_r[SYNC_N-1];
      end
   end

   // Data goes through the same depth, stays aligned with the strobe
   always_ff @(posedge i_clk) begin
      data_sync_r <= {data_sync_r[SYNC_N-2:0], i_xcom_data};
   end

   // Either strobe edge carries a bit
   assign s_toggle = clk_sync_r[SYNC_N-1] ^ clk_prev_r;
   assign s_bit    = data_sync_r[SYNC_N-1];

   ////////////////////
   // Frame decode
   ////////////////////
   // Toggles are ignored while checking or holding a frame
   assign s_shift_en = s_toggle && (state_r == LNK_IDLE || state_r == LNK_SHIFT);
   assign s_last_bit = (bit_cnt_r == CNT_W'(FRAME_N - 1));
   assign s_timeout  = (idle_cnt_r == TMO_W'(`XCOM_LINK_TIMEOUT - 1));
   assign s_dest     = shift_r[ID_MSB -: `XCOM_ID_BITS];
   // ID 0 is broadcast
   assign s_accept   = (s_dest == i_id) || (s_dest == '0);

   ////////////////////
   // Link FSM
   ////////////////////
   always_comb begin
      state_n = state_r;
      case (state_r)
         LNK_IDLE: begin
            // First bit of a new frame
            if (s_toggle) state_n = LNK_SHIFT;
         end
         LNK_SHIFT: begin
            if (s_toggle && s_last_bit) state_n = LNK_CHECK;
            // Strobe stalled mid-frame, drop it
            else if (!s_toggle && s_timeout) state_n = LNK_IDLE;
         end
         LNK_CHECK: begin
            state_n = s_accept ? LNK_HOLD : LNK_IDLE;
         end
         LNK_HOLD: begin
            if (i_ack) state_n = LNK_IDLE;
         end
         default: state_n = LNK_IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state_r    <= LNK_IDLE;
         bit_cnt_r  <= '0;
         idle_cnt_r <= '0;
      end else begin
         state_r <= state_n;
         // Bit count restarts whenever we fall back to idle
         if (state_n == LNK_IDLE) bit_cnt_r <= '0;
         else if (s_shift_en)     bit_cnt_r <= bit_cnt_r + 1'b1;
         // Cycles since the last toggle, only counted mid-frame
         if (state_r != LNK_SHIFT || s_toggle) idle_cnt_r <= '0;
         else                                  idle_cnt_r <= idle_cnt_r + 1'b1;
      end
   end

   // MSB first, so shift in at the bottom
   always_ff @(posedge i_clk) begin
      if (s_shift_en) shift_r <= {shift_r[FRAME_N-2:0], s_bit};
   end

   ////////////////////
   // Outputs
   ////////////////////
   // Shift register is frozen in HOLD, so the frame stays stable
   assign o_req         = (state_r == LNK_HOLD);
   assign o_frame.op    = op_t'(shift_r[FRAME_N-1 -: `XCOM_OP_BITS]);
   assign o_frame.data  = shift_r[`XCOM_DATA_BITS-1:0];
   assign o_dbg_state   = state_r;

endmodule

/* verilog/xcom_pkg.sv */
// Shared types for the command link receive side.
// Import inside module bodies; use scoped names in port lists.
`include "xcom_defines.svh"

package xcom_pkg;

   ////////////////////
   // Opcodes
   ////////////////////
   // Values 6 and up are illegal
   typedef enum logic [`XCOM_OP_BITS-1:0] {
      OP_NOP      = 4'd0,
      OP_LOAD     = 4'd1,
      OP_ADD      = 4'd2,
      OP_FLAG_SET = 4'd3,
      OP_FLAG_CLR = 4'd4,
      OP_SYNC     = 4'd5
   } op_t;

   ////////////////////
   // FSM states
   ////////////////////
   // 5 bits wide so it can drive the debug port as is
   typedef enum logic [4:0] {
      LNK_IDLE  = 5'd0,
      LNK_SHIFT = 5'd1,
      LNK_CHECK = 5'd2,
      LNK_HOLD  = 5'd3
   } link_state_t;

   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_REQ  = 2'd1,
      ARB_ACK  = 2'd2
   } arb_state_t;

   ////////////////////
   // Payload structs
   ////////////////////
   // Link receiver to arbiter, destination already filtered
   typedef struct packed {
      op_t                        op;
      logic [`XCOM_DATA_BITS-1:0] data;
   } xcom_frame_t;

   // Arbiter to executor, tagged with the receiving channel
   typedef struct packed {
      op_t                        op;
      logic [`XCOM_DATA_BITS-1:0] data;
      logic [`XCOM_CHID_BITS-1:0] chid;
   } xcom_cmd_t;

endpackage

/* include/xcom_defines.svh */
// Build-time constants for the command link receive side.
// Included by the package and by any module that sizes ports from these values.
`ifndef XCOM_DEFINES_SVH
`define XCOM_DEFINES_SVH

////////////////////
// Channel count
////////////////////
// Default number of serial receive channels
`define XCOM_NCH 2

// Channel index carried with each command
`define XCOM_CHID_BITS 4

////////////////////
// Frame layout
////////////////////
// Frame is op, destination, data, sent MSB first
`define XCOM_OP_BITS 4
`define XCOM_ID_BITS 4
`define XCOM_DATA_BITS 32
`define XCOM_FRAME_BITS 40

////////////////////
// Link timing
////////////////////
// Flops on each incoming wire before edge detection
`define XCOM_SYNC_STAGES 2

// Idle i_clk cycles before a partial frame is thrown away
`define XCOM_LINK_TIMEOUT 64

`endif
